//--- sim.f
common/oflow_pkg.sv
score_calc/oflow_score_calc_fsm.sv
score_calc/oflow_candidate_counter.sv
score_calc/oflow_similarity_metric.sv
score_calc/oflow_calc_min.sv
hdl/oflow_score_calc.sv
bench/oflow_score_calc_tb.sv

//--- Bender.yml
package:
  name: oflow_score_calc

sources:
  - files:
      - common/oflow_pkg.sv
      - score_calc/oflow_score_calc_fsm.sv
      - score_calc/oflow_candidate_counter.sv
      - score_calc/oflow_similarity_metric.sv
      - score_calc/oflow_calc_min.sv
      - hdl/oflow_score_calc.sv
  - target: test
    files:
      - bench/oflow_score_calc_tb.sv

//--- bench/oflow_score_calc_tb.sv
// Score stage testbench

`timescale 1ns/1ps

module oflow_score_calc_tb;

	import oflow_pkg::*;

	localparam int WIN_SIDE     = 4;                      // Window is 4x4 pixels
	localparam int FRAME_SIDE   = 8;                      // Candidate area with its margin
	localparam int MARGIN       = 2;                      // Largest negative shift
	localparam int BLOCK_CYCLES = N_CANDIDATES * (WIN_PIXELS + 3) + 1;
	localparam int FETCH_STEPS  = N_CANDIDATES * WIN_PIXELS + N_CANDIDATES - 1;
	localparam int N_BLOCKS     = 8;
	localparam int MAX_CYCLES   = N_BLOCKS * 320 + 100;   // Margin covers reset and gaps
	localparam int TIE_BASE     = 50;                     // Flat reference level for ties

	logic         clk;
	logic         reset_N;
	logic         start;
	pix_pair_t    pixels;
	fetch_t       fetch;
	flow_result_t result;
	logic         done;

	logic [PIX_W-1:0] ref_win [WIN_PIXELS];              // Reference window, row major
	logic [PIX_W-1:0] cand_frame [FRAME_SIDE*FRAME_SIDE]; // Search area, origin at MARGIN

	flow_result_t exp_result;
	int           exp_dx;
	int           exp_dy;
	string        test_name = "reset";
	int           errors = 0;
	int           blocks_run = 0;
	int           cycle_count = 0;
	int unsigned  seed;
	bit           started = 1'b0;                        // First start has been driven

	logic         blk_active;                            // Block accepted and not yet done
	int           blk_cycles;                            // Edges since the accepted start
	int           fetch_steps;                           // Fetch changes inside the block
	int           done_count;
	logic         holding;                               // Between done and the next start
	flow_result_t held_result;
	fetch_t       prev_fetch;

	oflow_score_calc UUT (
		.clk    (clk),
		.reset_N(reset_N),
		.start  (start),
		.pixels (pixels),
		.fetch  (fetch),
		.result (result),
		.done   (done)
	);

	// Two bit signed axis, dy sits above dx in the candidate index
	function automatic int axis_value(input int bits);
		int v;
		v = bits & 3;
		if (v >= 2) v -= 4;
		return v;
	endfunction

	function automatic int frame_addr(input int idx, input int dx, input int dy);
		return (idx / WIN_SIDE + dy + MARGIN) * FRAME_SIDE + idx % WIN_SIDE + dx + MARGIN;
	endfunction

	function automatic pix_pair_t pixel_pair_at(input fetch_t f);
		pix_pair_t p;
		p.ref_pix  = ref_win[f.pix_idx];
		p.cand_pix = cand_frame[frame_addr(f.pix_idx, axis_value(f.disp.raw),
		                                   axis_value(f.disp.raw >> 2))];
		return p;
	endfunction

	// Pixel index steps, wraps after the last pixel, then the candidate steps
	function automatic bit is_next_fetch(input fetch_t cur, input fetch_t nxt);
		if (nxt.disp.raw == cur.disp.raw)
			return nxt.pix_idx == PIX_IDX_W'((cur.pix_idx + 1) % WIN_PIXELS);
		return cur.pix_idx == '0 && nxt.pix_idx == '0
			&& cur.disp.raw != CAND_W'(N_CANDIDATES - 1) && nxt.disp.raw == cur.disp.raw + 1'b1;
	endfunction

	// SAD of every candidate in raw order, first strict minimum wins
	task automatic compute_reference();
		int raw;
		int idx;
		int dx;
		int dy;
		int sad;
		int diff;
		int best;
		best = -1;
		for (raw = 0; raw < N_CANDIDATES; raw++) begin
			dx  = axis_value(raw);
			dy  = axis_value(raw >> 2);
			sad = 0;
			for (idx = 0; idx < WIN_PIXELS; idx++) begin
				diff = int'(ref_win[idx]) - int'(cand_frame[frame_addr(idx, dx, dy)]);
				sad += (diff < 0) ? -diff : diff;
			end
			if (best < 0 || sad < best) begin
				best                = sad;
				exp_result.disp.raw = CAND_W'(raw);
				exp_dx              = dx;
				exp_dy              = dy;
			end
		end
		exp_result.score = SCORE_W'(best);
	endtask

	task automatic fill_random();
		int i;
		for (i = 0; i < WIN_PIXELS; i++) ref_win[i] = PIX_W'($urandom);
		for (i = 0; i < FRAME_SIDE * FRAME_SIDE; i++) cand_frame[i] = PIX_W'($urandom);
	endtask

	// One nibble per column and per row, so SAD splits into a column and a row sum
	task automatic fill_separable(input logic [31:0] col_pat, input logic [31:0] row_pat);
		int x;
		int y;
		for (x = 0; x < WIN_PIXELS; x++) ref_win[x] = PIX_W'(TIE_BASE);
		for (y = 0; y < FRAME_SIDE; y++)
			for (x = 0; x < FRAME_SIDE; x++)
				cand_frame[y*FRAME_SIDE + x] = PIX_W'(TIE_BASE + col_pat[4*x +: 4] + row_pat[4*y +: 4]);
	endtask

	task automatic run_block(input string name, input bit busy_start, input int gap);
		int n0;
		n0        = done_count;
		test_name = name;
		compute_reference();
		start     = 1'b1;                                // Called on a falling edge
		started   = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (busy_start) begin
			repeat (100) @(negedge clk);                 // Well inside the candidate walk
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
		end
		while (done_count == n0) @(negedge clk);
		blocks_run++;
		repeat (gap) @(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always_comb pixels = pixel_pair_at(fetch);          // Memory answers in the same cycle

	always @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			blk_active  <= 1'b0;
			blk_cycles  <= 0;
			fetch_steps <= 0;
			done_count  <= 0;
			holding     <= 1'b0;
			held_result <= '0;
			prev_fetch  <= '0;
		end else begin
			prev_fetch <= fetch;
			if (start && !blk_active) begin              // Only a start from idle counts
				blk_active  <= 1'b1;
				blk_cycles  <= 1;
				fetch_steps <= 0;
				holding     <= 1'b0;
			end else if (blk_active) begin
				blk_cycles <= blk_cycles + 1;
				if (blk_cycles > 1 && fetch != prev_fetch) fetch_steps <= fetch_steps + 1;
			end
			if (done) begin
				blk_active  <= 1'b0;
				done_count  <= done_count + 1;
				holding     <= 1'b1;
				held_result <= result;
			end
		end
	end

	a_reset_quiet: assert property (@(posedge clk) disable iff (!reset_N)
		!started |-> !done && result == '0 && fetch == '0)
		else begin
			errors++;
			$display("CHECK FAILED %s: idle outputs expected 0, actual done %0b result %h fetch %h",
				test_name, $sampled(done), $sampled(result), $sampled(fetch));
		end

	a_done_timing: assert property (@(posedge clk) disable iff (!reset_N)
		done |-> blk_active && blk_cycles == BLOCK_CYCLES)
		else begin
			errors++;
			$display("CHECK FAILED %s: done cycle expected %0d, actual %0d",
				test_name, BLOCK_CYCLES, $sampled(blk_cycles));
		end

	a_done_pulse: assert property (@(posedge clk) disable iff (!reset_N) done |=> !done)
		else begin
			errors++;
			$display("CHECK FAILED %s: done one cycle after done expected 0, actual 1", test_name);
		end

	a_result: assert property (@(posedge clk) disable iff (!reset_N) done |-> result == exp_result)
		else begin
			errors++;
			$display("CHECK FAILED %s: result expected %h, actual %h",
				test_name, exp_result, $sampled(result));
		end

	a_disp: assert property (@(posedge clk) disable iff (!reset_N)
		done |-> int'(result.disp.vec.dx) == exp_dx && int'(result.disp.vec.dy) == exp_dy)
		else begin
			errors++;
			$display("CHECK FAILED %s: dx/dy expected %0d/%0d, actual %0d/%0d", test_name,
				exp_dx, exp_dy, int'($sampled(result.disp.vec.dx)), int'($sampled(result.disp.vec.dy)));
		end

	a_fetch_step: assert property (@(posedge clk) disable iff (!reset_N)
		blk_active && blk_cycles > 1 && fetch != prev_fetch |-> is_next_fetch(prev_fetch, fetch))
		else begin
			errors++;
			$display("CHECK FAILED %s: fetch after %h expected next in order, actual %h",
				test_name, $sampled(prev_fetch), $sampled(fetch));
		end

	a_fetch_count: assert property (@(posedge clk) disable iff (!reset_N)
		done |-> fetch_steps == FETCH_STEPS)
		else begin
			errors++;
			$display("CHECK FAILED %s: fetch steps expected %0d, actual %0d",
				test_name, FETCH_STEPS, $sampled(fetch_steps));
		end

	a_hold: assert property (@(posedge clk) disable iff (!reset_N) holding |-> result == held_result)
		else begin
			errors++;
			$display("CHECK FAILED %s: held result expected %h, actual %h",
				test_name, $sampled(held_result), $sampled(result));
		end

	initial begin
		seed    = $urandom(32'hab76);                    // Seeds the generator for the run
		start   = 1'b0;
		reset_N = 1'b0;
		fill_random();
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset_N = 1'b1;
		repeat (4) @(negedge clk);                       // Idle outputs watched before any start
		fill_random();
		run_block("random_single", 1'b0, 3);
		fill_random();
		run_block("random_busy_start", 1'b1, 5);
		fill_separable(32'h5551_0001, 32'h5552_0000);    // dy -2 ties dx -2 with dx -1
		run_block("tie_negative", 1'b0, 2);
		fill_separable(32'h0000_1555, 32'h0100_0155);    // dx +1 ties dy 0 with dy +1
		run_block("tie_positive", 1'b0, 0);
		repeat (N_BLOCKS - 4) begin
			fill_random();
			run_block($sformatf("random_back_to_back_%0d", blocks_run), 1'b0, 0);
		end
		repeat (4) @(negedge clk);
		$display("Blocks run: %0d, errors: %0d", blocks_run, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		errors++;
		$display("Timeout after %0d cycles, test %s never saw done", MAX_CYCLES, test_name);
		$display("Blocks run: %0d, errors: %0d", blocks_run, errors);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- hdl/oflow_score_calc.sv
// Optical flow score stage top

`timescale 1ns/1ps

module oflow_score_calc (
	input  logic                    clk,
	input  logic                    reset_N,
	input  logic                    start,    // One cycle block request
	input  oflow_pkg::pix_pair_t    pixels,   // Memory answer for fetch, same cycle
	output oflow_pkg::fetch_t       fetch,
	output oflow_pkg::flow_result_t result,
	output logic                    done
);

	import oflow_pkg::*;

	logic               start_similarity_metric;
	logic               metric_busy;
	logic               start_calc_min;
	logic               first_candidate;
	logic               next_candidate;
	logic               done_similarity_metric;
	logic               done_calc_min;
	logic               last_pixel;
	logic               last_candidate;
	logic [SCORE_W-1:0] score;                // SAD of the candidate just finished

	oflow_score_calc_fsm u_fsm (
		.clk                    (clk),
		.reset_N                (reset_N),
		.start                  (start),
		.done_similarity_metric (done_similarity_metric),
		.done_calc_min          (done_calc_min),
		.last_pixel             (last_pixel),
		.last_candidate         (last_candidate),
		.start_similarity_metric(start_similarity_metric),
		.metric_busy            (metric_busy),
		.start_calc_min         (start_calc_min),
		.first_candidate        (first_candidate),
		.next_candidate         (next_candidate),
		.done                   (done)
	);

	oflow_candidate_counter u_counter (
		.clk           (clk),
		.reset_N       (reset_N),
		.start         (start),
		.metric_busy   (metric_busy),
		.next_candidate(next_candidate),
		.fetch         (fetch),
		.last_pixel    (last_pixel),
		.last_candidate(last_candidate)
	);

	oflow_similarity_metric u_metric (
		.clk                    (clk),
		.reset_N                (reset_N),
		.start_similarity_metric(start_similarity_metric),
		.metric_busy            (metric_busy),
		.pixels                 (pixels),
		.last_pixel             (last_pixel),
		.score                  (score),
		.done_similarity_metric (done_similarity_metric)
	);

	// Displacement is still the scored candidate when the compare runs
	oflow_calc_min u_calc_min (
		.clk            (clk),
		.reset_N        (reset_N),
		.start_calc_min (start_calc_min),
		.first_candidate(first_candidate),
		.score          (score),
		.disp           (fetch.disp),
		.result         (result),
		.done_calc_min  (done_calc_min)
	);

endmodule

//--- score_calc/oflow_calc_min.sv
// Running minimum of SAD scores

`timescale 1ns/1ps

module oflow_calc_min (
	input  logic                          clk,
	input  logic                          reset_N,
	input  logic                          start_calc_min,   // Score of a candidate is ready
	input  logic                          first_candidate,  // Load rather than compare
	input  logic [oflow_pkg::SCORE_W-1:0] score,
	input  oflow_pkg::disp_t              disp,             // Candidate that produced score
	output oflow_pkg::flow_result_t       result,
	output logic                          done_calc_min
);

	import oflow_pkg::*;

	logic better;

	// Strictly lower, so the earlier candidate keeps a tie
	assign better = first_candidate || (score < result.score);

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			result        <= '0;
			done_calc_min <= 1'b0;
		end else begin
			done_calc_min <= start_calc_min;    // Single cycle compare
			if (start_calc_min && better) begin
				result.score <= score;
				result.disp  <= disp;
			end
		end
	end

endmodule

//--- score_calc/oflow_similarity_metric.sv
// SAD accumulator

`timescale 1ns/1ps

module oflow_similarity_metric (
	input  logic                          clk,
	input  logic                          reset_N,
	input  logic                          start_similarity_metric,  // Clear the sum
	input  logic                          metric_busy,              // Add this cycle's pair
	input  oflow_pkg::pix_pair_t          pixels,
	input  logic                          last_pixel,
	output logic [oflow_pkg::SCORE_W-1:0] score,
	output logic                          done_similarity_metric
);

	import oflow_pkg::*;

	logic [PIX_W-1:0]   abs_diff;
	logic [SCORE_W-1:0] acc;

	// Unsigned distance between the two pixels
	assign abs_diff = (pixels.ref_pix > pixels.cand_pix) ? pixels.ref_pix - pixels.cand_pix
	                                                      : pixels.cand_pix - pixels.ref_pix;
	assign score = acc;                       // Stable until the next clear

	always_ff @(posedge clk) begin
		if (start_similarity_metric) acc <= '0;
		else if (metric_busy) acc <= acc + SCORE_W'(abs_diff);
	end

	// Done lands one cycle after the last addition
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) done_similarity_metric <= 1'b0;
		else done_similarity_metric <= metric_busy & last_pixel;
	end

	// Sixteen pixel pairs must fit in SCORE_W bits
	a_no_wrap: assert property (@(posedge clk) disable iff (!reset_N)
		metric_busy |=> acc >= $past(acc));

endmodule

//--- score_calc/oflow_candidate_counter.sv
// Candidate and pixel counter

`timescale 1ns/1ps

module oflow_candidate_counter (
	input  logic             clk,
	input  logic             reset_N,
	input  logic             start,           // Block request, only taken when not running
	input  logic             metric_busy,     // Step the pixel index
	input  logic             next_candidate,  // Step the candidate index
	output oflow_pkg::fetch_t fetch,
	output logic             last_pixel,
	output logic             last_candidate
);

	import oflow_pkg::*;

	logic [PIX_IDX_W-1:0] pix_idx;
	disp_t                cand;
	logic                 running;            // A block is walking the candidates

	assign fetch.disp     = cand;
	assign fetch.pix_idx  = pix_idx;
	assign last_pixel     = (pix_idx == PIX_IDX_W'(WIN_PIXELS - 1));
	assign last_candidate = (cand.raw == CAND_W'(N_CANDIDATES - 1));

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			pix_idx <= '0;
			cand    <= '0;
			running <= 1'b0;
		end else begin
			if (start && !running) begin
				pix_idx  <= '0;
				cand.raw <= '0;
				running  <= 1'b1;
			end else begin
				if (metric_busy) pix_idx <= pix_idx + 1'b1;          // Wraps to 0 after the last pixel
				if (next_candidate) cand.raw <= cand.raw + 1'b1;     // Raw order, dy:dx
				// Final pixel of the final candidate ends the walk
				if (metric_busy && last_pixel && last_candidate) running <= 1'b0;
			end
		end
	end

	// Candidate steps only between windows, never mid accumulation
	a_step_outside_window: assert property (@(posedge clk) disable iff (!reset_N)
		!(next_candidate && metric_busy));

endmodule

//--- score_calc/oflow_score_calc_fsm.sv
// Block sequencer FSM

`timescale 1ns/1ps

module oflow_score_calc_fsm (
	input  logic clk,
	input  logic reset_N,
	input  logic start,                       // Block request from outside
	input  logic done_similarity_metric,      // SAD of the current candidate is ready
	input  logic done_calc_min,               // Running minimum updated
	input  logic last_pixel,                  // Counter is on the final pixel
	input  logic last_candidate,              // Counter is on the final candidate
	output logic start_similarity_metric,     // Clears the SAD accumulator
	output logic metric_busy,                 // Accumulate and step the pixel index
	output logic start_calc_min,              // Compare the fresh score
	output logic first_candidate,             // Load instead of compare
	output logic next_candidate,              // Step the candidate index
	output logic done                         // Block finished, result is final
);

	typedef enum logic [1:0] {idle_st, metric_st, min_wait_st, advance_st} sm_type;

	sm_type current_state;
	sm_type next_state;
	logic   first_q;                          // Candidate 0 has not been scored yet
	logic   last_q;                           // Sampled last_candidate of the running candidate
	logic   busy_q;

	assign metric_busy     = busy_q;
	assign first_candidate = start_calc_min & first_q;  // Only on the compare of candidate 0

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) current_state <= idle_st;
		else current_state <= next_state;
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			first_q <= 1'b0;
			last_q  <= 1'b0;
			busy_q  <= 1'b0;
		end else begin
			if (current_state == idle_st && start) first_q <= 1'b1;
			else if (start_calc_min) first_q <= 1'b0;
			if (start_similarity_metric) busy_q <= 1'b1;
			else if (busy_q && last_pixel) busy_q <= 1'b0;   // Drop after pixel 15
			// The counter may be restarted before this candidate closes, so keep its flag
			if (busy_q && last_pixel) last_q <= last_candidate;
		end
	end

	always_comb begin
		next_state              = current_state;
		start_similarity_metric = 1'b0;
		start_calc_min          = 1'b0;
		next_candidate          = 1'b0;
		done                    = 1'b0;

		case (current_state)
			idle_st: begin
				if (start) next_state = advance_st;     // Start is ignored elsewhere
			end
			metric_st: begin
				if (done_similarity_metric) begin
					start_calc_min = 1'b1;
					next_state     = min_wait_st;
				end
			end
			min_wait_st: begin
				if (done_calc_min) next_state = advance_st;
			end
			advance_st: begin
				if (first_q) begin                      // Launch candidate 0
					start_similarity_metric = 1'b1;
					next_state              = metric_st;
				end else if (last_q) begin
					done       = 1'b1;
					next_state = idle_st;
				end else begin
					next_candidate          = 1'b1;
					start_similarity_metric = 1'b1;
					next_state              = metric_st;
				end
			end
			default: next_state = idle_st;
		endcase
	end

	// The compare starts a cycle after the last addition and the minimum answers a cycle later
	a_min_follows_metric: assert property (@(posedge clk) disable iff (!reset_N)
		start_calc_min |-> $past(metric_busy && last_pixel) ##1 done_calc_min);

	// The block ends only with the accumulator idle
	a_done_not_with_start: assert property (@(posedge clk) disable iff (!reset_N)
		!(done && (start_similarity_metric || metric_busy)));

endmodule

//--- common/oflow_pkg.sv
// Optical flow score stage
// Shared sizes and types

package oflow_pkg;

	localparam int PIX_W        = 8;              // Bits per pixel
	localparam int WIN_PIXELS   = 16;             // 4x4 window
	localparam int PIX_IDX_W    = 4;              // Pixel index inside a window
	localparam int N_CANDIDATES = 16;             // Displacements -2..+1 in both axes
	localparam int DXY_W        = 2;              // One signed displacement axis
	localparam int CAND_W       = 2 * DXY_W;      // Raw candidate index
	localparam int SCORE_W      = 12;             // Holds 16 * 255 without overflow

	// Signed view of a candidate, dy sits in the upper bits
	typedef struct packed {
		logic signed [DXY_W-1:0] dy;              // Vertical displacement
		logic signed [DXY_W-1:0] dx;              // Horizontal displacement
	} disp_vec_t;

	// Counted as a raw index, read back as a dx/dy pair
	typedef union packed {
		logic [CAND_W-1:0] raw;                   // Candidate number 0..15
		disp_vec_t         vec;                   // Decoded displacement
	} disp_t;

	// Address sent to the pixel memory
	typedef struct packed {
		disp_t                disp;               // Candidate being scored
		logic [PIX_IDX_W-1:0] pix_idx;            // Pixel inside the window
	} fetch_t;

	// Pixel pair returned by the memory
	typedef struct packed {
		logic [PIX_W-1:0] ref_pix;                // Reference window pixel
		logic [PIX_W-1:0] cand_pix;               // Displaced candidate pixel
	} pix_pair_t;

	// Best match of a block
	typedef struct packed {
		logic [SCORE_W-1:0] score;                // Lowest SAD seen
		disp_t              disp;                 // Where it was found
	} flow_result_t;

endpackage
